// ==== hw/mul_pkg.sv ====
//////////////////////////////
// Multiply-accumulate package
// Widths, opcodes, sequencer state codes
// and the operand word view shared by the MAC blocks
//////////////////////////////

`default_nettype none

package mul_pkg;

        // Datapath widths
        localparam int DATA_W   = 32;
        localparam int HALF_W   = 16;
        localparam int FACTOR_W = 17;
        localparam int PROD_W   = 34;
        localparam int ACC_W    = 64;
        localparam int OP_W     = 4;

        // Operation codes, long ops come as a low and a high pass
        localparam logic [OP_W-1:0] OP_NONE     = 4'd0;
        localparam logic [OP_W-1:0] OP_UMLAL_LO = 4'd1;
        localparam logic [OP_W-1:0] OP_UMLAL_HI = 4'd2;
        localparam logic [OP_W-1:0] OP_SMLAL_LO = 4'd3;
        localparam logic [OP_W-1:0] OP_SMLAL_HI = 4'd4;
        // Halfword MAC, first digit picks the rm half, second the rs half
        localparam logic [OP_W-1:0] OP_SMLA00   = 4'd5;
        localparam logic [OP_W-1:0] OP_SMLA01   = 4'd6;
        localparam logic [OP_W-1:0] OP_SMLA10   = 4'd7;
        localparam logic [OP_W-1:0] OP_SMLA11   = 4'd8;

        // Sequencer states
        localparam logic [2:0] ST_IDLE     = 3'd0;
        localparam logic [2:0] ST_SUM_LOW  = 3'd1;
        localparam logic [2:0] ST_SUM_HIGH = 3'd2;
        localparam logic [2:0] ST_DONE     = 3'd3;
        localparam logic [2:0] ST_DONE_SAT = 3'd4;

        // One register word, seen whole or as two halves
        typedef union packed {
                logic [DATA_W-1:0] word;
                struct packed {
                        logic [HALF_W-1:0] hi;
                        logic [HALF_W-1:0] lo;
                } half;
        } operand_word_u;

endpackage

`default_nettype wire

// ==== hw/mul_if.sv ====
//////////////////////////////
// MAC internal bundles
// factor_if carries the four factors and decoded flags
// product_if carries the four registered partial products
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface factor_if
        import mul_pkg::*;
();
        // Signed 17 bit factors, rm = {a,c} and rs = {b,d}
        logic signed [FACTOR_W-1:0] a;
        logic signed [FACTOR_W-1:0] b;
        logic signed [FACTOR_W-1:0] c;
        logic signed [FACTOR_W-1:0] d;

        // Decoded operation flags
        logic start;
        logic high_pass;
        logic halfword_mac;

        modport source (output a, b, c, d, start, high_pass, halfword_mac);
        modport sink   (input a, b, c, d);
        modport ctrl   (input start, high_pass, halfword_mac);
endinterface

interface product_if
        import mul_pkg::*;
();
        // 34 bit signed partial products
        logic signed [PROD_W-1:0] ab;
        logic signed [PROD_W-1:0] bc;
        logic signed [PROD_W-1:0] ad;
        logic signed [PROD_W-1:0] cd;

        modport source (output ab, bc, ad, cd);
        modport sink   (input ab, bc, ad, cd);
endinterface

`default_nettype wire

// ==== hw/mul_operand_select.sv ====
//////////////////////////////
// MAC operand selector
// Decodes the opcode into control flags and
// splits rm and rs into four signed 17 bit factors
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_operand_select
        import mul_pkg::*;
(
        input  wire logic [OP_W-1:0]   i_op,
        input  wire logic [DATA_W-1:0] i_rm,
        input  wire logic [DATA_W-1:0] i_rs,
        factor_if.source               o_fac
);

// Decoded flags
logic start;
logic high_pass;
logic halfword;
logic signed_long;
logic rm_hi_sel;
logic rs_hi_sel;

// Operand views and picked halves
operand_word_u     rm_w;
operand_word_u     rs_w;
logic [HALF_W-1:0] rm_half;
logic [HALF_W-1:0] rs_half;

//////////////////////////////
// Opcode decode
//////////////////////////////

always_comb
begin
        start       = 1'b1;
        high_pass   = 1'b0;
        halfword    = 1'b0;
        signed_long = 1'b0;
        rm_hi_sel   = 1'b0;
        rs_hi_sel   = 1'b0;

        case (i_op)
        OP_NONE:     start = 1'b0;
        OP_UMLAL_LO: high_pass = 1'b0;
        OP_UMLAL_HI: high_pass = 1'b1;
        OP_SMLAL_LO: signed_long = 1'b1;
        OP_SMLAL_HI:
        begin
                signed_long = 1'b1;
                high_pass   = 1'b1;
        end
        OP_SMLA00:   halfword = 1'b1;
        OP_SMLA01:
        begin
                halfword  = 1'b1;
                rs_hi_sel = 1'b1;
        end
        OP_SMLA10:
        begin
                halfword  = 1'b1;
                rm_hi_sel = 1'b1;
        end
        OP_SMLA11:
        begin
                halfword  = 1'b1;
                rm_hi_sel = 1'b1;
                rs_hi_sel = 1'b1;
        end
        // Unknown codes do nothing
        default:     start = 1'b0;
        endcase
end

//////////////////////////////
// Factor forming
//////////////////////////////

always_comb
begin
        rm_w    = i_rm;
        rs_w    = i_rs;
        rm_half = rm_hi_sel ? rm_w.half.hi : rm_w.half.lo;
        rs_half = rs_hi_sel ? rs_w.half.hi : rs_w.half.lo;

        if (halfword)
        begin
                // Upper factor is only the sign of the picked half
                o_fac.a = {FACTOR_W{rm_half[HALF_W-1]}};
                o_fac.b = {FACTOR_W{rs_half[HALF_W-1]}};
                o_fac.c = {1'b0, rm_half};
                o_fac.d = {1'b0, rs_half};
        end
        else
        begin
                // Long ops, sign bit of the whole word extends the upper half
                o_fac.a = {signed_long & rm_w.word[DATA_W-1], rm_w.half.hi};
                o_fac.b = {signed_long & rs_w.word[DATA_W-1], rs_w.half.hi};
                o_fac.c = {1'b0, rm_w.half.lo};
                o_fac.d = {1'b0, rs_w.half.lo};
        end
end

assign o_fac.start        = start;
assign o_fac.high_pass    = high_pass;
assign o_fac.halfword_mac = halfword;

endmodule

`default_nettype wire

// ==== hw/mul_partial_products.sv ====
//////////////////////////////
// MAC partial product array
// Four registered 17x17 signed multipliers,
// one per DSP slice, free running
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_partial_products
        import mul_pkg::*;
(
        input  wire logic i_clk,
        factor_if.sink    i_fac,
        product_if.source o_prod
);

// Full width signed products of the current factors
logic signed [PROD_W-1:0] ab_nxt;
logic signed [PROD_W-1:0] bc_nxt;
logic signed [PROD_W-1:0] ad_nxt;
logic signed [PROD_W-1:0] cd_nxt;

always_comb
begin
        // 17 x 17 gives 34 bits, no overflow possible
        ab_nxt = i_fac.a * i_fac.b;
        bc_nxt = i_fac.b * i_fac.c;
        ad_nxt = i_fac.a * i_fac.d;
        cd_nxt = i_fac.c * i_fac.d;
end

//////////////////////////////
// Product registers
//////////////////////////////

// No stall here, the caller holds operands while busy
always_ff @(posedge i_clk)
begin
        o_prod.ab <= ab_nxt;
        o_prod.bc <= bc_nxt;
        o_prod.ad <= ad_nxt;
        o_prod.cd <= cd_nxt;
end

endmodule

`default_nettype wire

// ==== hw/mul_sequencer.sv ====
//////////////////////////////
// MAC sequencer
// Sums partial products into a 64 bit accumulator,
// adds rh:rn, checks halfword saturation and
// returns the low or high word with busy and nozero
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_sequencer
        import mul_pkg::*;
(
        input  wire logic              i_clk,
        input  wire logic              i_reset,
        input  wire logic              i_clear,
        input  wire logic              i_stall,
        input  wire logic [DATA_W-1:0] i_rn,
        input  wire logic [DATA_W-1:0] i_rh,
        factor_if.ctrl                 i_fac,
        product_if.sink                i_prod,
        output logic [DATA_W-1:0]      o_rd,
        output logic                   o_sat,
        output logic                   o_busy,
        output logic                   o_nozero
);

// FSM and accumulator
logic [2:0]              state_ff;
logic [2:0]              state_nxt;
logic signed [ACC_W-1:0] acc_ff;
logic signed [ACC_W-1:0] acc_nxt;

// Low word of the last low pass was nonzero
logic nozero_ff;
logic nozero_nxt;

// Signed 32 bit overflow on the rn add
logic sat_hit;

// Products sign extended to accumulator width
logic signed [ACC_W-1:0] ab_x;
logic signed [ACC_W-1:0] bc_x;
logic signed [ACC_W-1:0] ad_x;
logic signed [ACC_W-1:0] cd_x;

always_comb
begin
        ab_x = {{(ACC_W-PROD_W){i_prod.ab[PROD_W-1]}}, i_prod.ab};
        bc_x = {{(ACC_W-PROD_W){i_prod.bc[PROD_W-1]}}, i_prod.bc};
        ad_x = {{(ACC_W-PROD_W){i_prod.ad[PROD_W-1]}}, i_prod.ad};
        cd_x = {{(ACC_W-PROD_W){i_prod.cd[PROD_W-1]}}, i_prod.cd};
end

//////////////////////////////
// Next state and outputs
//////////////////////////////

always_comb
begin
        state_nxt  = state_ff;
        acc_nxt    = acc_ff;
        nozero_nxt = nozero_ff;
        sat_hit    = 1'b0;
        o_busy     = 1'b1;
        o_rd       = '0;
        o_sat      = 1'b0;
        o_nozero   = 1'b0;

        case (state_ff)
        ST_IDLE:
        begin
                // Busy rises in the same cycle as the op
                o_busy = i_fac.start;
                if (i_fac.start)
                        state_nxt = i_fac.high_pass ? ST_DONE : ST_SUM_LOW;
        end

        ST_SUM_LOW:
        begin
                // Lower products, cross terms weigh 2^16
                acc_nxt   = cd_x + (bc_x << HALF_W) + (ad_x << HALF_W);
                state_nxt = ST_SUM_HIGH;
        end

        ST_SUM_HIGH:
        begin
                // Upper product plus the accumulate pair
                acc_nxt = acc_ff + (ab_x << DATA_W) + {i_rh, i_rn};

                // Product and rn same sign, result sign flipped
                sat_hit = i_fac.halfword_mac &&
                          (acc_nxt[DATA_W-1] != acc_ff[DATA_W-1]) &&
                          (acc_ff[DATA_W-1] == i_rn[DATA_W-1]);

                state_nxt = sat_hit ? ST_DONE_SAT : ST_DONE;
        end

        ST_DONE, ST_DONE_SAT:
        begin
                o_busy    = 1'b0;
                o_sat     = (state_ff == ST_DONE_SAT);
                state_nxt = ST_IDLE;

                if (i_fac.high_pass)
                begin
                        o_rd     = acc_ff[ACC_W-1:DATA_W];
                        // Keep the zero flag clear if low word had bits set
                        o_nozero = nozero_ff;
                end
                else
                begin
                        o_rd       = acc_ff[DATA_W-1:0];
                        nozero_nxt = |acc_ff[DATA_W-1:0];
                end
        end

        default:
        begin
                o_busy    = 1'b0;
                state_nxt = ST_IDLE;
        end
        endcase
end

//////////////////////////////
// Registers
//////////////////////////////

// Reset over clear over stall
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                state_ff  <= ST_IDLE;
                nozero_ff <= 1'b0;
        end
        else if (!i_stall)
        begin
                state_ff  <= state_nxt;
                nozero_ff <= nozero_nxt;
        end
end

// Accumulator holds on stall and on clear
always_ff @(posedge i_clk)
begin
        if (!i_clear && !i_stall)
                acc_ff <= acc_nxt;
end

endmodule

`default_nettype wire

// ==== hw/mul_top.sv ====
//////////////////////////////
// Multi-cycle MAC top level
// Operand select, partial products and
// sequencer joined to plain pipeline ports
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_top
        import mul_pkg::*;
(
        input  wire logic              i_clk,
        input  wire logic              i_reset,
        input  wire logic              i_clear,
        input  wire logic              i_stall,
        input  wire logic [OP_W-1:0]   i_op,
        input  wire logic [DATA_W-1:0] i_rm,
        input  wire logic [DATA_W-1:0] i_rn,
        input  wire logic [DATA_W-1:0] i_rh,
        input  wire logic [DATA_W-1:0] i_rs,
        output logic [DATA_W-1:0]      o_rd,
        output logic                   o_sat,
        output logic                   o_busy,
        output logic                   o_nozero
);

// Factors and flags, then registered products
factor_if  fac ();
product_if prod ();

// Combinational decode and split
mul_operand_select u_select (
        .i_op  (i_op),
        .i_rm  (i_rm),
        .i_rs  (i_rs),
        .o_fac (fac.source)
);

// One cycle multiplier array
mul_partial_products u_products (
        .i_clk  (i_clk),
        .i_fac  (fac.sink),
        .o_prod (prod.source)
);

// Summing FSM and result path
mul_sequencer u_sequencer (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clear  (i_clear),
        .i_stall  (i_stall),
        .i_rn     (i_rn),
        .i_rh     (i_rh),
        .i_fac    (fac.ctrl),
        .i_prod   (prod.sink),
        .o_rd     (o_rd),
        .o_sat    (o_sat),
        .o_busy   (o_busy),
        .o_nozero (o_nozero)
);

endmodule

`default_nettype wire

// ==== verification/mul_properties.sv ====
//////////////////////////////
// MAC handshake properties
// Latency, result-cycle outputs and reset state
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_properties
        import mul_pkg::*;
(
        input wire logic              i_clk,
        input wire logic              i_reset,
        input wire logic              i_clear,
        input wire logic              i_stall,
        input wire logic [OP_W-1:0]   i_op,
        input wire logic [DATA_W-1:0] o_rd,
        input wire logic              o_sat,
        input wire logic              o_busy,
        input wire logic              o_nozero
);

logic high_op;
logic low_op;

assign high_op = (i_op == OP_UMLAL_HI) || (i_op == OP_SMLAL_HI);
// Long low passes and halfword forms take the full three cycles
assign low_op  = (i_op != OP_NONE) && !high_op && (i_op <= OP_SMLA11);

// Low pass result three cycles after the op appears
assert property (@(posedge i_clk) disable iff (i_reset || i_clear || i_stall)
        (o_busy && !$past(o_busy) && low_op) |=> o_busy ##1 o_busy ##1 !o_busy)
else $error("low pass result not in cycle 3");

// High pass result in the next cycle
assert property (@(posedge i_clk) disable iff (i_reset || i_clear || i_stall)
        (o_busy && !$past(o_busy) && high_op) |=> !o_busy)
else $error("high pass result not in cycle 1");

// Outputs read zero outside the result cycle
assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
        !($past(o_busy) && !o_busy) |-> (o_rd == '0 && !o_sat && !o_nozero))
else $error("result outputs nonzero outside the result cycle");

// Nozero only on a high pass
assert property (@(posedge i_clk) disable iff (i_reset)
        o_nozero |-> high_op)
else $error("nozero raised outside a high pass");

// Idle after reset
assert property (@(posedge i_clk)
        i_reset |=> (i_op != OP_NONE) || !o_busy)
else $error("busy high after reset");

endmodule

bind mul_top mul_properties u_properties (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clear  (i_clear),
        .i_stall  (i_stall),
        .i_op     (i_op),
        .o_rd     (o_rd),
        .o_sat    (o_sat),
        .o_busy   (o_busy),
        .o_nozero (o_nozero)
);

`default_nettype wire

// ==== verification/mul_tb.sv ====
//////////////////////////////
// MAC testbench
// Long and halfword multiply-accumulate against a
// reference model, plus stall, clear and nozero checks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mul_tb
        import mul_pkg::*;
;

localparam int N_TESTS     = 58;
localparam int TIMEOUT_CYC = N_TESTS * 10 + 100;

logic              i_clk;
logic              i_reset;
logic              i_clear;
logic              i_stall;
logic [OP_W-1:0]   i_op;
logic [DATA_W-1:0] i_rm;
logic [DATA_W-1:0] i_rn;
logic [DATA_W-1:0] i_rh;
logic [DATA_W-1:0] i_rs;
logic [DATA_W-1:0] o_rd;
logic              o_sat;
logic              o_busy;
logic              o_nozero;

// Random source and test bookkeeping
logic [31:0] lfsr;
bit          test_ok;
int          n_tests;
int          n_fail;

mul_top UUT (.*);

always #10 i_clk = ~i_clk;

//////////////////////////////
// Random words and reference
//////////////////////////////

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++)
        begin
                w    = {w[30:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
        end
endtask

// rm * rs + rh:rn over 64 bits
function automatic logic [63:0] long_model(input bit sgn, input logic [31:0] rm, rs, rn, rh);
        logic [63:0] a;
        logic [63:0] b;
        a = sgn ? {{32{rm[31]}}, rm} : {32'b0, rm};
        b = sgn ? {{32{rs[31]}}, rs} : {32'b0, rs};
        return a * b + {rh, rn};
endfunction

// Saturation flag above the 32 bit sum
function automatic logic [32:0] half_model(input logic [1:0] sel, input logic [31:0] rm, rs, rn);
        logic signed [15:0] hm;
        logic signed [15:0] hs;
        logic signed [63:0] sum;
        bit                 ovf;
        hm  = sel[1] ? rm[31:16] : rm[15:0];
        hs  = sel[0] ? rs[31:16] : rs[15:0];
        sum = hm * hs + $signed(rn);
        // Overflow when the exact sum leaves the signed 32 bit range
        ovf = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
        return {ovf, sum[31:0]};
endfunction

//////////////////////////////
// Checking and handshake
//////////////////////////////

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else
        begin
                $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
                test_ok = 0;
        end
endtask

task automatic end_test(input string name);
        n_tests++;
        if (test_ok)
                $display("OK %s", name);
        else
                n_fail++;
        test_ok = 1;
endtask

task automatic issue(input logic [OP_W-1:0] op, input logic [31:0] rm, rs, rn, rh);
        @(negedge i_clk);
        i_op = op;
        i_rm = rm;
        i_rs = rs;
        i_rn = rn;
        i_rh = rh;
endtask

// Counts cycles until busy drops while the operands stay held
task automatic wait_result(inout int cyc);
        do
        begin
                @(negedge i_clk);
                cyc++;
        end
        while (o_busy);
endtask

//////////////////////////////
// Tests
//////////////////////////////

task automatic long_pair(input bit sgn, input logic [31:0] rm, rs, rn, rh);
        logic [63:0] exp;
        string       tag;
        int          cyc;
        exp = long_model(sgn, rm, rs, rn, rh);
        tag = sgn ? "smlal" : "umlal";
        issue(sgn ? OP_SMLAL_LO : OP_UMLAL_LO, rm, rs, rn, rh);
        cyc = 0;
        wait_result(cyc);
        check({tag, "_lo latency"}, 64'd3, 64'(cyc));
        check({tag, "_lo rd"}, {32'b0, exp[31:0]}, {32'b0, o_rd});
        check({tag, "_lo sat"}, 64'd0, {63'b0, o_sat});
        end_test({tag, "_lo"});
        // High pass takes the kept accumulator
        issue(sgn ? OP_SMLAL_HI : OP_UMLAL_HI, rm, rs, rn, rh);
        cyc = 0;
        wait_result(cyc);
        check({tag, "_hi latency"}, 64'd1, 64'(cyc));
        check({tag, "_hi rd"}, {32'b0, exp[63:32]}, {32'b0, o_rd});
        check({tag, "_hi nozero"}, {63'b0, |exp[31:0]}, {63'b0, o_nozero});
        end_test({tag, "_hi"});
endtask

task automatic half_mac(input logic [1:0] sel, input logic [31:0] rm, rs, rn);
        logic [32:0]     exp;
        logic [OP_W-1:0] op;
        string           tag;
        int              cyc;
        exp = half_model(sel, rm, rs, rn);
        tag = $sformatf("smla%b", sel);
        case (sel)
        2'b00:   op = OP_SMLA00;
        2'b01:   op = OP_SMLA01;
        2'b10:   op = OP_SMLA10;
        default: op = OP_SMLA11;
        endcase
        issue(op, rm, rs, rn, 32'h0);
        cyc = 0;
        wait_result(cyc);
        check({tag, " latency"}, 64'd3, 64'(cyc));
        check({tag, " rd"}, {32'b0, exp[31:0]}, {32'b0, o_rd});
        check({tag, " sat"}, {63'b0, exp[32]}, {63'b0, o_sat});
        end_test(tag);
endtask

// Stall held in SUM_LOW for n cycles
task automatic stall_test(input int n, input logic [31:0] rm, rs);
        logic [63:0] exp;
        string       tag;
        int          cyc;
        exp = long_model(1'b1, rm, rs, 32'h0, 32'h0);
        tag = $sformatf("stall_%0d", n);
        issue(OP_SMLAL_LO, rm, rs, 32'h0, 32'h0);
        @(negedge i_clk);
        cyc     = 1;
        i_stall = 1;
        repeat (n) @(negedge i_clk);
        cyc     = cyc + n;
        i_stall = 0;
        wait_result(cyc);
        check({tag, " latency"}, 64'(3 + n), 64'(cyc));
        check({tag, " rd"}, {32'b0, exp[31:0]}, {32'b0, o_rd});
        end_test(tag);
endtask

// Reset in the middle of a low pass returns the FSM to idle
task automatic reset_test();
        issue(OP_UMLAL_LO, 32'h3, 32'h5, 32'h0, 32'h0);
        @(negedge i_clk);
        i_reset = 1;
        i_op    = OP_NONE;
        @(negedge i_clk);
        i_reset = 0;
        check("reset busy", 64'd0, {63'b0, o_busy});
        end_test("reset");
endtask

task automatic clear_test();
        int cyc;
        issue(OP_SMLAL_LO, 32'h3, 32'h5, 32'h0, 32'h0);
        @(negedge i_clk);
        i_clear = 1;
        i_op    = OP_NONE;
        @(negedge i_clk);
        check("clear busy", 64'd0, {63'b0, o_busy});
        i_clear = 0;
        issue(OP_SMLAL_HI, 32'h3, 32'h5, 32'h0, 32'h0);
        cyc = 0;
        wait_result(cyc);
        check("clear nozero", 64'd0, {63'b0, o_nozero});
        end_test("clear");
endtask

//////////////////////////////
// Main sequence
//////////////////////////////

initial
begin
        logic [31:0] rm;
        logic [31:0] rs;
        logic [31:0] rn;
        logic [31:0] rh;
        i_clk   = 0;
        i_reset = 1;
        i_clear = 0;
        i_stall = 0;
        i_op    = OP_NONE;
        i_rm    = '0;
        i_rn    = '0;
        i_rh    = '0;
        i_rs    = '0;
        lfsr    = 32'h271b;
        test_ok = 1;
        n_tests = 0;
        n_fail  = 0;
        repeat (3) @(negedge i_clk);
        i_reset = 0;

        // Corner values
        long_pair(1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
        long_pair(1'b0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
        long_pair(1'b1, 32'h8000_8000, 32'h8000_8000, 32'h0, 32'h0);
        long_pair(1'b1, 32'hffff_ffff, 32'h1, 32'h0, 32'h0);
        long_pair(1'b0, 32'h0, 32'h1234_5678, 32'h0, 32'h5);
        long_pair(1'b1, 32'h7fff_ffff, 32'h8000_0000, 32'h1, 32'h0);
        half_mac(2'b11, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff);
        half_mac(2'b00, 32'h0000_8000, 32'h0000_8000, 32'h0);
        half_mac(2'b01, 32'h0000_8000, 32'h7fff_0000, 32'h8000_0000);
        half_mac(2'b10, 32'hffff_0000, 32'h0000_0001, 32'h0);

        for (int i = 0; i < 10; i++)
        begin
                rand_word(rm);
                rand_word(rs);
                rand_word(rn);
                rand_word(rh);
                long_pair(i[0], rm, rs, rn, rh);
        end
        for (int i = 0; i < 16; i++)
        begin
                rand_word(rm);
                rand_word(rs);
                rand_word(rn);
                half_mac(i[1:0], rm, rs, rn);
        end

        stall_test(1, 32'h1234_5678, 32'h9abc_def0);
        stall_test(4, 32'hdead_beef, 32'h0000_8000);
        reset_test();
        long_pair(1'b0, 32'h7, 32'h9, 32'h0, 32'h0);
        clear_test();

        @(negedge i_clk);
        i_op = OP_NONE;
        repeat (2) @(negedge i_clk);
        $display("Tests run %0d, failed %0d", n_tests, n_fail);
        if (n_fail == 0)
                $display("Testbench passed");
        else
                $display("Testbench failed");
        $finish;
end

// Watchdog
initial
begin
        repeat (TIMEOUT_CYC) @(posedge i_clk);
        $display("Timeout after %0d cycles, the DUT never finished", TIMEOUT_CYC);
        $display("Testbench failed");
        $finish;
end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/mul_pkg.sv
hw/mul_if.sv
hw/mul_operand_select.sv
hw/mul_partial_products.sv
hw/mul_sequencer.sv
hw/mul_top.sv
verification/mul_properties.sv
verification/mul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mul_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
